//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f \
    --top-module geometry_frontend_tb \
    --Mdir obj_dir -o geometry_frontend_tb

./obj_dir/geometry_frontend_tb > sim.log 2>&1
cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    exit 0
fi
exit 1

//--- sim.f
+incdir+src
+incdir+test
src/raster_pkg.sv
src/stream_skid_buffer.sv
src/triangle_assembler.sv
src/fixed_reciprocal_divider.sv
src/triangle_projection.sv
src/backface_cull.sv
src/geometry_frontend.sv
test/geometry_frontend_tb.sv

//--- src/backface_cull.sv
`default_nettype none

module backface_cull (
    input  logic                         clk,
    input  logic                         rstn,
    input  raster_pkg::tagged_triangle_t triangle_s_data,
    input  logic                         triangle_s_valid,
    output logic                         triangle_s_ready,
    output raster_pkg::tagged_triangle_t triangle_m_data,
    output logic                         triangle_m_valid,
    input  logic                         triangle_m_ready
);

    import raster_pkg::*;

    fixed area;
    logic keep;
    logic accept;

    // Twice the signed screen area, positive for front-facing winding
    always_comb begin
        area = sub(mul(sub(triangle_s_data.triangle.v1.position.x,
                           triangle_s_data.triangle.v0.position.x),
                       sub(triangle_s_data.triangle.v2.position.y,
                           triangle_s_data.triangle.v0.position.y)),
                   mul(sub(triangle_s_data.triangle.v2.position.x,
                           triangle_s_data.triangle.v0.position.x),
                       sub(triangle_s_data.triangle.v1.position.y,
                           triangle_s_data.triangle.v0.position.y)));
    end

    assign keep             = (area > 0) || triangle_s_data.double_sided;
    assign triangle_s_ready = !triangle_m_valid || triangle_m_ready;
    assign accept           = triangle_s_valid && triangle_s_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            triangle_m_valid <= 1'b0;
        end else if (triangle_s_ready) begin
            // Culled triangles are taken in and never shown
            triangle_m_valid <= accept && keep;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            triangle_m_data <= triangle_s_data;
        end
    end

endmodule

`default_nettype wire

//--- src/fixed_reciprocal_divider.sv
`default_nettype none

`include "raster_consts.svh"

module fixed_reciprocal_divider (
    input  logic             clk,
    input  logic             rstn,
    input  raster_pkg::fixed divisor_s_data,
    input  logic             divisor_s_valid,
    output logic             divisor_s_ready,
    output raster_pkg::fixed result_m_data,
    output logic             result_m_valid
);

    localparam int W     = `FIXED_WIDTH;
    // One quotient bit for each bit of the 2^(2*FRAC_BITS) dividend
    localparam int ITERS = 2 * `FRAC_BITS + 1;
    localparam int CW    = $clog2(ITERS + 1);

    logic            busy;
    logic [CW-1:0]   iter;
    logic [W-1:0]    divisor_q;
    logic [W-1:0]    rem_q;
    logic [W-1:0]    quo_q;
    logic [W:0]      trial;
    logic [W:0]      diff;
    logic            take;
    logic            accept;

    assign divisor_s_ready = !busy;
    assign accept          = divisor_s_valid && divisor_s_ready;

    // Dividend bits are a lone one followed by zeros
    assign trial = {rem_q, iter == '0};
    assign diff  = trial - {1'b0, divisor_q};
    assign take  = trial >= {1'b0, divisor_q};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy           <= 1'b0;
            iter           <= '0;
            result_m_valid <= 1'b0;
        end else begin
            result_m_valid <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                iter <= '0;
            end else if (busy) begin
                if (iter == CW'(ITERS - 1)) begin
                    busy           <= 1'b0;
                    result_m_valid <= 1'b1;
                end
                iter <= iter + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            divisor_q <= divisor_s_data;
            rem_q     <= '0;
        end else if (busy) begin
            rem_q <= take ? diff[W-1:0] : trial[W-1:0];
            // Top quotient bit shifts out, leaving the truncated result
            quo_q <= {quo_q[W-2:0], take};
        end
    end

    assign result_m_data = quo_q;

endmodule

`default_nettype wire

//--- src/geometry_frontend.sv
`default_nettype none

`include "raster_consts.svh"

module geometry_frontend #(
    parameter raster_pkg::camera_intrinsics_t intrinsics = '{
        fx: `DEFAULT_FX,
        fy: `DEFAULT_FY,
        cx: `DEFAULT_CX,
        cy: `DEFAULT_CY
    }
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  raster_pkg::tagged_vertex_t   vertex_s_data,
    input  logic                         vertex_s_valid,
    output logic                         vertex_s_ready,
    output raster_pkg::tagged_triangle_t triangle_m_data,
    output logic                         triangle_m_valid,
    input  logic                         triangle_m_ready
);

    import raster_pkg::*;

    tagged_vertex_t   skid_vertex;
    logic             skid_vertex_valid;
    logic             skid_vertex_ready;
    tagged_triangle_t asm_triangle;
    logic             asm_valid;
    logic             asm_ready;
    tagged_triangle_t proj_triangle;
    logic             proj_valid;
    logic             proj_ready;
    tagged_triangle_t cull_triangle;
    logic             cull_valid;
    logic             cull_ready;

    stream_skid_buffer #(.payload_t(tagged_vertex_t)) u_in_skid (
        .clk    (clk),
        .rstn   (rstn),
        .s_data (vertex_s_data),
        .s_valid(vertex_s_valid),
        .s_ready(vertex_s_ready),
        .m_data (skid_vertex),
        .m_valid(skid_vertex_valid),
        .m_ready(skid_vertex_ready)
    );

    triangle_assembler u_assembler (
        .clk             (clk),
        .rstn            (rstn),
        .vertex_s_data   (skid_vertex),
        .vertex_s_valid  (skid_vertex_valid),
        .vertex_s_ready  (skid_vertex_ready),
        .triangle_m_data (asm_triangle),
        .triangle_m_valid(asm_valid),
        .triangle_m_ready(asm_ready)
    );

    triangle_projection #(.intrinsics(intrinsics)) u_projection (
        .clk              (clk),
        .rstn             (rstn),
        .triangle_s_data  (asm_triangle),
        .triangle_s_valid (asm_valid),
        .triangle_s_ready (asm_ready),
        .projected_m_data (proj_triangle),
        .projected_m_valid(proj_valid),
        .projected_m_ready(proj_ready)
    );

    backface_cull u_cull (
        .clk             (clk),
        .rstn            (rstn),
        .triangle_s_data (proj_triangle),
        .triangle_s_valid(proj_valid),
        .triangle_s_ready(proj_ready),
        .triangle_m_data (cull_triangle),
        .triangle_m_valid(cull_valid),
        .triangle_m_ready(cull_ready)
    );

    stream_skid_buffer #(.payload_t(tagged_triangle_t)) u_out_skid (
        .clk    (clk),
        .rstn   (rstn),
        .s_data (cull_triangle),
        .s_valid(cull_valid),
        .s_ready(cull_ready),
        .m_data (triangle_m_data),
        .m_valid(triangle_m_valid),
        .m_ready(triangle_m_ready)
    );

endmodule

`default_nettype wire

//--- src/raster_consts.svh
`ifndef RASTER_CONSTS_SVH
`define RASTER_CONSTS_SVH

// Signed Q16.16
`define FIXED_WIDTH 32
`define FRAC_BITS   16

`define COLOR_WIDTH 8

// Camera intrinsics as raw fixed values
`define DEFAULT_FX 32'sh0045_0000
`define DEFAULT_FY 32'sh0045_0000
`define DEFAULT_CX 32'sh0050_0000
`define DEFAULT_CY 32'sh003c_0000

`endif

//--- src/raster_pkg.sv
`default_nettype none

`include "raster_consts.svh"

package raster_pkg;

    typedef logic signed [`FIXED_WIDTH-1:0] fixed;

    typedef struct packed {
        fixed x;
        fixed y;
        fixed z;
    } vec3_t;

    typedef struct packed {
        logic [`COLOR_WIDTH-1:0] r;
        logic [`COLOR_WIDTH-1:0] g;
        logic [`COLOR_WIDTH-1:0] b;
    } color_t;

    typedef struct packed {
        vec3_t  position;
        color_t color;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef struct packed {
        vertex_t vertex;
        logic    double_sided;
    } tagged_vertex_t;

    typedef struct packed {
        triangle_t triangle;
        logic      double_sided;
    } tagged_triangle_t;

    typedef struct packed {
        fixed fx;
        fixed fy;
        fixed cx;
        fixed cy;
    } camera_intrinsics_t;

    // Full product, back to Q16.16 by dropping the low fraction bits
    function automatic fixed mul(fixed a, fixed b);
        logic signed [2*`FIXED_WIDTH-1:0] prod;
        prod = a * b;
        return prod[`FRAC_BITS +: `FIXED_WIDTH];
    endfunction

    function automatic fixed add(fixed a, fixed b);
        return a + b;
    endfunction

    function automatic fixed sub(fixed a, fixed b);
        return a - b;
    endfunction

    // floor(2^32 / z), z positive
    function automatic fixed recip(fixed z);
        logic [2*`FIXED_WIDTH-1:0] quo;
        quo = (64'd1 << (2 * `FRAC_BITS)) / {{`FIXED_WIDTH{1'b0}}, z};
        return quo[`FIXED_WIDTH-1:0];
    endfunction

endpackage

`default_nettype wire

//--- src/stream_skid_buffer.sv
`default_nettype none

module stream_skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstn,
    input  payload_t s_data,
    input  logic     s_valid,
    output logic     s_ready,
    output payload_t m_data,
    output logic     m_valid,
    input  logic     m_ready
);

    payload_t skid_data;
    logic     skid_valid;
    logic     main_load;

    // Output register free to take a new item
    assign main_load = m_ready || !m_valid;
    assign s_ready   = !skid_valid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            m_valid    <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_load) begin
            m_valid    <= skid_valid || s_valid;
            skid_valid <= 1'b0;
        end else if (s_valid && s_ready) begin
            // Output stalled, park the new item
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            m_data <= skid_valid ? skid_data : s_data;
        end else if (s_valid && s_ready) begin
            skid_data <= s_data;
        end
    end

endmodule

`default_nettype wire

//--- src/triangle_assembler.sv
`default_nettype none

module triangle_assembler (
    input  logic                         clk,
    input  logic                         rstn,
    input  raster_pkg::tagged_vertex_t   vertex_s_data,
    input  logic                         vertex_s_valid,
    output logic                         vertex_s_ready,
    output raster_pkg::tagged_triangle_t triangle_m_data,
    output logic                         triangle_m_valid,
    input  logic                         triangle_m_ready
);

    logic [1:0] slot;
    logic       accept;

    // No new vertices while a full triangle waits
    assign vertex_s_ready = !triangle_m_valid;
    assign accept         = vertex_s_valid && vertex_s_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            slot             <= 2'd0;
            triangle_m_valid <= 1'b0;
        end else begin
            if (triangle_m_valid && triangle_m_ready) begin
                triangle_m_valid <= 1'b0;
            end
            if (accept) begin
                if (slot == 2'd2) begin
                    slot             <= 2'd0;
                    triangle_m_valid <= 1'b1;
                end else begin
                    slot <= slot + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            case (slot)
                2'd0: triangle_m_data.triangle.v0 <= vertex_s_data.vertex;
                2'd1: triangle_m_data.triangle.v1 <= vertex_s_data.vertex;
                default: begin
                    triangle_m_data.triangle.v2  <= vertex_s_data.vertex;
                    // Flag of the closing vertex tags the triangle
                    triangle_m_data.double_sided <= vertex_s_data.double_sided;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/triangle_projection.sv
`default_nettype none

`include "raster_consts.svh"

module triangle_projection #(
    parameter raster_pkg::camera_intrinsics_t intrinsics = '{
        fx: `DEFAULT_FX,
        fy: `DEFAULT_FY,
        cx: `DEFAULT_CX,
        cy: `DEFAULT_CY
    }
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  raster_pkg::tagged_triangle_t triangle_s_data,
    input  logic                         triangle_s_valid,
    output logic                         triangle_s_ready,
    output raster_pkg::tagged_triangle_t projected_m_data,
    output logic                         projected_m_valid,
    input  logic                         projected_m_ready
);

    import raster_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_DIV0,
        S_DIV1,
        S_DIV2,
        S_PROJ,
        S_OUT
    } state_t;

    state_t           state;
    state_t           next_state;
    tagged_triangle_t t_in;
    tagged_triangle_t t_out;
    fixed             rec_z0;
    fixed             rec_z1;
    fixed             rec_z2;
    fixed             current_z;
    logic             in_div;
    logic             issued;
    logic             divisor_valid;
    logic             divisor_ready;
    logic             recip_valid;
    fixed             recip;

    // p' = f * p * (1/z) + c
    function automatic fixed project_coord(fixed f, fixed p, fixed rz, fixed c);
        return add(mul(f, mul(p, rz)), c);
    endfunction

    function automatic vertex_t project_vertex(vertex_t v, fixed rz);
        vertex_t pv;
        pv.position.x = project_coord(intrinsics.fx, v.position.x, rz, intrinsics.cx);
        pv.position.y = project_coord(intrinsics.fy, v.position.y, rz, intrinsics.cy);
        pv.position.z = rz;
        pv.color      = v.color;
        return pv;
    endfunction

    fixed_reciprocal_divider u_divider (
        .clk            (clk),
        .rstn           (rstn),
        .divisor_s_data (current_z),
        .divisor_s_valid(divisor_valid),
        .divisor_s_ready(divisor_ready),
        .result_m_data  (recip),
        .result_m_valid (recip_valid)
    );

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: if (triangle_s_valid) next_state = S_DIV0;
            S_DIV0: if (recip_valid) next_state = S_DIV1;
            S_DIV1: if (recip_valid) next_state = S_DIV2;
            S_DIV2: if (recip_valid) next_state = S_PROJ;
            S_PROJ: next_state = S_OUT;
            S_OUT:  if (projected_m_ready) next_state = S_IDLE;
            default: next_state = S_IDLE;
        endcase
    end

    always_comb begin
        case (state)
            S_DIV1:  current_z = t_in.triangle.v1.position.z;
            S_DIV2:  current_z = t_in.triangle.v2.position.z;
            default: current_z = t_in.triangle.v0.position.z;
        endcase
    end

    assign triangle_s_ready  = (state == S_IDLE);
    assign projected_m_valid = (state == S_OUT);
    assign in_div            = (state == S_DIV0) || (state == S_DIV1) || (state == S_DIV2);
    // One divide per state, never reissued in the result cycle
    assign divisor_valid     = in_div && !issued;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state  <= S_IDLE;
            issued <= 1'b0;
        end else begin
            state <= next_state;
            if (recip_valid) begin
                issued <= 1'b0;
            end else if (divisor_valid && divisor_ready) begin
                issued <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (triangle_s_valid && triangle_s_ready) begin
            t_in <= triangle_s_data;
        end
        if (recip_valid) begin
            case (state)
                S_DIV0:  rec_z0 <= recip;
                S_DIV1:  rec_z1 <= recip;
                default: rec_z2 <= recip;
            endcase
        end
        if (state == S_PROJ) begin
            t_out.triangle.v0  <= project_vertex(t_in.triangle.v0, rec_z0);
            t_out.triangle.v1  <= project_vertex(t_in.triangle.v1, rec_z1);
            t_out.triangle.v2  <= project_vertex(t_in.triangle.v2, rec_z2);
            t_out.double_sided <= t_in.double_sided;
        end
    end

    assign projected_m_data = t_out;

endmodule

`default_nettype wire

//--- test/projection_model.svh
`ifndef PROJECTION_MODEL_SVH
`define PROJECTION_MODEL_SVH

// Screen coordinate f * (p * (1/z)) + c
function automatic fixed screen_coord(fixed f, fixed p, fixed rz, fixed c);
    return add(mul(f, mul(p, rz)), c);
endfunction

function automatic vertex_t project_point(vertex_t v);
    vertex_t p;
    fixed    rz;
    rz           = recip(v.position.z);
    p.position.x = screen_coord(`DEFAULT_FX, v.position.x, rz, `DEFAULT_CX);
    p.position.y = screen_coord(`DEFAULT_FY, v.position.y, rz, `DEFAULT_CY);
    p.position.z = rz;
    p.color      = v.color;
    return p;
endfunction

function automatic tagged_triangle_t project_triangle(tagged_triangle_t t);
    tagged_triangle_t p;
    p.triangle.v0  = project_point(t.triangle.v0);
    p.triangle.v1  = project_point(t.triangle.v1);
    p.triangle.v2  = project_point(t.triangle.v2);
    p.double_sided = t.double_sided;
    return p;
endfunction

// Twice the signed screen area
function automatic fixed signed_area(triangle_t t);
    return sub(mul(sub(t.v1.position.x, t.v0.position.x), sub(t.v2.position.y, t.v0.position.y)),
               mul(sub(t.v2.position.x, t.v0.position.x), sub(t.v1.position.y, t.v0.position.y)));
endfunction

function automatic logic survives_cull(tagged_triangle_t p);
    return (signed_area(p.triangle) > 0) || p.double_sided;
endfunction

`endif

//--- test/geometry_frontend_tb.sv
`default_nettype none

`include "raster_consts.svh"

module geometry_frontend_tb;

    import raster_pkg::*;

    `include "projection_model.svh"

    localparam int CLK_PERIOD          = 20;
    localparam int RESET_CYCLES        = 16;
    localparam int NUM_VERTICES        = 600;
    localparam int NUM_TRIANGLES       = NUM_VERTICES / 3;
    localparam int CYCLES_PER_TRIANGLE = 150;
    localparam int DRAIN_LIMIT         = 1000;
    localparam int QUIET_CYCLES        = 200;

    logic             clk;
    logic             rstn;
    tagged_vertex_t   vertex_s_data;
    logic             vertex_s_valid;
    logic             vertex_s_ready;
    tagged_triangle_t triangle_m_data;
    logic             triangle_m_valid;
    logic             triangle_m_ready;

    logic [31:0]      lcg_state;
    tagged_triangle_t expected_q[$];
    tagged_vertex_t   pending_verts[3];
    tagged_triangle_t held_data;
    logic             hold_pending;
    logic             in_fire;
    int               vert_slot;
    int               sent;
    int               received;
    int               culled;
    int               drain_cycles;
    int               value_errors;
    int               stream_errors;

    geometry_frontend u_geometry_frontend (
        .clk             (clk),
        .rstn            (rstn),
        .vertex_s_data   (vertex_s_data),
        .vertex_s_valid  (vertex_s_valid),
        .vertex_s_ready  (vertex_s_ready),
        .triangle_m_data (triangle_m_data),
        .triangle_m_valid(triangle_m_valid),
        .triangle_m_ready(triangle_m_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(NUM_TRIANGLES * CYCLES_PER_TRIANGLE * CLK_PERIOD);
        $display("Timeout: run did not finish in %0d cycles", NUM_TRIANGLES * CYCLES_PER_TRIANGLE);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // -8.0 .. 8.0
    function automatic fixed pick_coord();
        logic [31:0] r;
        r = next_random();
        return fixed'({8'd0, r[31:8]} % 32'd1048577) - 32'sd524288;
    endfunction

    // 1.0 .. 64.0
    function automatic fixed pick_depth();
        logic [31:0] r;
        r = next_random();
        return fixed'({8'd0, r[31:8]} % 32'd4128769) + 32'sd65536;
    endfunction

    function automatic tagged_vertex_t random_vertex();
        tagged_vertex_t v;
        logic [31:0]    r;
        v.vertex.position.x = pick_coord();
        v.vertex.position.y = pick_coord();
        v.vertex.position.z = pick_depth();
        r                   = next_random();
        v.vertex.color      = r[31:8];
        r                   = next_random();
        v.double_sided      = (r[31:30] == 2'b00);
        return v;
    endfunction

    task automatic check_equal(input string name, input logic [383:0] actual,
                               input logic [383:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            value_errors++;
        end
    endtask

    task automatic compare_triangle(input tagged_triangle_t got, input tagged_triangle_t want);
        vertex_t got_v[3];
        vertex_t want_v[3];
        got_v  = '{got.triangle.v0, got.triangle.v1, got.triangle.v2};
        want_v = '{want.triangle.v0, want.triangle.v1, want.triangle.v2};
        for (int i = 0; i < 3; i++) begin
            check_equal($sformatf("triangle_m_data.v%0d.x", i),
                        $unsigned(got_v[i].position.x), $unsigned(want_v[i].position.x));
            check_equal($sformatf("triangle_m_data.v%0d.y", i),
                        $unsigned(got_v[i].position.y), $unsigned(want_v[i].position.y));
            check_equal($sformatf("triangle_m_data.v%0d.z", i),
                        $unsigned(got_v[i].position.z), $unsigned(want_v[i].position.z));
            check_equal($sformatf("triangle_m_data.v%0d.color", i),
                        got_v[i].color, want_v[i].color);
        end
        check_equal("triangle_m_data.double_sided", got.double_sided, want.double_sided);
    endtask

    // Every third accepted vertex closes a triangle for the model
    task automatic record_vertex(input tagged_vertex_t v);
        tagged_triangle_t assembled;
        tagged_triangle_t projected;
        pending_verts[vert_slot] = v;
        vert_slot++;
        sent++;
        if (vert_slot == 3) begin
            vert_slot              = 0;
            assembled.triangle.v0  = pending_verts[0].vertex;
            assembled.triangle.v1  = pending_verts[1].vertex;
            assembled.triangle.v2  = pending_verts[2].vertex;
            assembled.double_sided = pending_verts[2].double_sided;
            projected              = project_triangle(assembled);
            if (survives_cull(projected)) begin
                expected_q.push_back(projected);
            end else begin
                culled++;
            end
        end
    endtask

    // One falling edge worth of driving and checking
    task automatic service_streams();
        logic [31:0] r;
        if (hold_pending) begin
            check_equal("triangle_m_valid", triangle_m_valid, 1'b1);
            check_equal("triangle_m_data", triangle_m_data, held_data);
        end
        r                = next_random();
        triangle_m_ready = r[31];
        if (triangle_m_valid && triangle_m_ready) begin
            received++;
            if (expected_q.size() == 0) begin
                $display("Extra triangle at %0t when none was expected", $time);
                stream_errors++;
            end else begin
                compare_triangle(triangle_m_data, expected_q.pop_front());
            end
        end
        hold_pending = triangle_m_valid && !triangle_m_ready;
        held_data    = triangle_m_data;

        if (in_fire) begin
            record_vertex(vertex_s_data);
            vertex_s_valid = 1'b0;
        end
        if (!vertex_s_valid && sent < NUM_VERTICES) begin
            r = next_random();
            if (r[31:30] != 2'b00) begin
                vertex_s_data  = random_vertex();
                vertex_s_valid = 1'b1;
            end
        end
        // Ready is registered, so this edge's transfer is known now
        in_fire = vertex_s_valid && vertex_s_ready;
    endtask

    initial begin
        rstn             = 1'b0;
        vertex_s_data    = '0;
        vertex_s_valid   = 1'b0;
        triangle_m_ready = 1'b0;
        lcg_state        = 32'h162c59de;
        held_data        = '0;
        hold_pending     = 1'b0;
        in_fire          = 1'b0;
        vert_slot        = 0;
        sent             = 0;
        received         = 0;
        culled           = 0;
        value_errors     = 0;
        stream_errors    = 0;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_equal("triangle_m_valid", triangle_m_valid, 1'b0);
            check_equal("vertex_s_ready", vertex_s_ready, 1'b1);
        end
        rstn = 1'b1;
        @(negedge clk);
        check_equal("triangle_m_valid", triangle_m_valid, 1'b0);
        check_equal("vertex_s_ready", vertex_s_ready, 1'b1);

        while (sent < NUM_VERTICES) begin
            @(negedge clk);
            service_streams();
        end

        drain_cycles = 0;
        while (expected_q.size() > 0 && drain_cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            service_streams();
            drain_cycles++;
        end
        if (expected_q.size() > 0) begin
            $display("Missing triangles: %0d expected triangles never came out",
                     expected_q.size());
            stream_errors += expected_q.size();
        end

        // Nothing more may come out
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            service_streams();
        end

        $display("Errors: %0d value, %0d stream (%0d triangles received, %0d culled)",
                 value_errors, stream_errors, received, culled);
        if (value_errors == 0 && stream_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
